/* include/forth_defines.svh */
// Widths and the memory map are fixed for the whole core; the token queue depth must stay a power of two
`ifndef FORTH_DEFINES_SVH
`define FORTH_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// One Forth cell
`define CELL_W 32
// Program address, covers ROM plus RAM
`define ADDR_W 10

// Circular stack depths
`define DSTACK_DEPTH 16
`define RSTACK_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// Memory map and I/O
////////////////////////////////////////////////////////////////////////////

// First RAM address, boot ROM lies below
`define ROM_TOP 200
`define RAM_DEPTH 256
// Token FIFO slots, also the host's starting credits
`define XTQ_DEPTH 2
// Clocks per serial bit
`define BAUD_DIV 625
// ROM idle loop entry
`define IDLE_LOOP 0

`endif

/* verilog/forth_pkg.sv */
// Shared types of the Forth core; the cell layout assumes a 32-bit cell with opcodes in the low 16 bits
`include "forth_defines.svh"

package forth_pkg;

	// Kept opcodes
	typedef enum logic [15:0] {
		op_execute,
		op_exit,
		op_lit,
		op_plus,
		op_minus,
		op_one_plus,
		op_dup,
		op_over,
		op_drop,
		op_equal,
		op_zero_equal,
		op_zero_less_than,
		op_and,
		op_or,
		op_not,
		op_negate,
		op_zero_branch,
		op_branch,
		op_emit,
		op_io_led,
		op_io_button
	} op_e;

	// Instruction view of a cell
	// Call flag set means the negated cell is the target
	typedef struct packed {
		logic        call;
		logic [14:0] spare;
		op_e         op;
	} instr_t;

	// One memory cell, read as a number or as an instruction
	typedef union packed {
		logic signed [`CELL_W-1:0] data;
		instr_t                    instr;
	} cell_u;

	// Host code write
	typedef struct packed {
		logic               valid;
		logic [`ADDR_W-1:0] addr;
		logic [`CELL_W-1:0] data;
	} code_wr_t;

	// Data stack operations, all 16 codes in use
	typedef enum logic [3:0] {
		ds_none,
		ds_push,
		ds_pop,
		ds_add,
		ds_sub,
		ds_inc,
		ds_dup,
		ds_over,
		ds_eq,
		ds_zeq,
		ds_zlt,
		ds_and,
		ds_or,
		ds_not,
		ds_neg,
		ds_replace
	} ds_op_e;

	typedef struct packed {
		ds_op_e             op;
		logic [`CELL_W-1:0] arg;
	} ds_cmd_t;

	// Return stack command
	typedef struct packed {
		logic               push;
		logic               pop;
		logic [`ADDR_W-1:0] ret_addr;
	} rs_cmd_t;

endpackage

/* verilog/program_memory.sv */
// Boot ROM is a fixed image; RAM has no reset value and host writes outside RAM or during reset are dropped
`timescale 1ns/1ps
`include "forth_defines.svh"

module program_memory import forth_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [`ADDR_W-1:0] mem_addr,
	input  code_wr_t           code_wr,
	output cell_u              mem_cell
);

	localparam int RAM_AW = $clog2(`RAM_DEPTH);
	localparam logic [`ADDR_W-1:0] RAM_BASE = `ADDR_W'(`ROM_TOP);
	localparam logic [`ADDR_W-1:0] RAM_END = `ADDR_W'(`ROM_TOP + `RAM_DEPTH);

	logic [`CELL_W-1:0] ram [`RAM_DEPTH];
	logic [`ADDR_W-1:0] wr_off;
	logic [`ADDR_W-1:0] rd_off;
	logic               wr_hit;

	////////////////////////////////////////////////////////////////////////////
	// Boot ROM image
	////////////////////////////////////////////////////////////////////////////

	function automatic cell_u rom_cell(input logic [`ADDR_W-1:0] addr);
		cell_u c;
		c = '0;
		case (addr)
			// Idle loop, wait for a token then loop back
			0: c.instr.op = op_execute;
			1: c.instr.op = op_branch;
			2: c.data = `IDLE_LOOP;
			// Error word prints '?'
			11: c.instr.op = op_lit;
			12: c.data = 32'h3f;
			13: c.instr.op = op_emit;
			14: c.instr.op = op_exit;
			// led word
			17: c.instr.op = op_io_led;
			18: c.instr.op = op_exit;
			// Unused ROM just returns
			default: c.instr.op = op_exit;
		endcase
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Code RAM
	////////////////////////////////////////////////////////////////////////////

	assign wr_off = code_wr.addr - RAM_BASE;
	assign rd_off = mem_addr - RAM_BASE;
	// Only the RAM window is writable
	assign wr_hit = code_wr.valid && code_wr.addr >= RAM_BASE && code_wr.addr < RAM_END;

	always_ff @(posedge clk) begin
		if (reset && wr_hit) begin
			ram[wr_off[RAM_AW-1:0]] <= code_wr.data;
		end
	end

	// Same-cycle read, ROM below ROM_TOP
	always_comb begin
		if (mem_addr < RAM_BASE) begin
			mem_cell = rom_cell(mem_addr);
		end else if (mem_addr < RAM_END) begin
			mem_cell = ram[rd_off[RAM_AW-1:0]];
		end else begin
			// Past RAM reads as exit
			mem_cell = '0;
			mem_cell.instr.op = op_exit;
		end
	end

endmodule

/* verilog/xt_queue.sv */
// Token FIFO sized by XTQ_DEPTH, a power of two; the host may push only while it holds a credit
`timescale 1ns/1ps
`include "forth_defines.svh"

module xt_queue (
	input  logic               clk,
	input  logic               reset,
	input  logic               xt_push,
	input  logic [`ADDR_W-1:0] xt_addr,
	input  logic               xt_pop,
	output logic               xt_valid,
	output logic [`ADDR_W-1:0] xt_head,
	output logic               xt_credit
);

	localparam int PTR_W = $clog2(`XTQ_DEPTH);
	localparam int CNT_W = $clog2(`XTQ_DEPTH + 1);

	logic [`ADDR_W-1:0] slot [`XTQ_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               do_pop;

	assign xt_valid = count != '0;
	assign xt_head  = slot[rd_ptr];
	assign do_pop   = xt_pop && xt_valid;

	// Pointers wrap on their own width
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			xt_credit <= 1'b0;
		end else begin
			// One credit back per token taken
			xt_credit <= do_pop;
			if (xt_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({xt_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Token storage
	always_ff @(posedge clk) begin
		if (xt_push) begin
			slot[wr_ptr] <= xt_addr;
		end
	end

	// Host credit count must keep the queue from overflowing
	assert property (@(posedge clk) disable iff (!reset)
		xt_push |-> count < CNT_W'(`XTQ_DEPTH))
		else $error("token pushed into full queue");

endmodule

/* verilog/data_stack.sv */
// Circular data stack of DSTACK_DEPTH cells; it wraps silently on overflow and underflow
`timescale 1ns/1ps
`include "forth_defines.svh"

module data_stack import forth_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  ds_cmd_t            cmd,
	output logic [`CELL_W-1:0] tos,
	output logic [`CELL_W-1:0] nos
);

	localparam int PTR_W = $clog2(`DSTACK_DEPTH);

	logic [`CELL_W-1:0] cells [`DSTACK_DEPTH];
	logic [PTR_W-1:0]   dp;
	logic [PTR_W-1:0]   dp_up;
	logic [PTR_W-1:0]   dp_dn;
	logic [PTR_W-1:0]   nxt_dp;
	logic [PTR_W-1:0]   wr_ptr;
	logic [`CELL_W-1:0] result;
	logic               wr_en;

	assign dp_up = dp + 1'b1;
	assign dp_dn = dp - 1'b1;
	assign tos   = cells[dp];
	assign nos   = cells[dp_dn];

	////////////////////////////////////////////////////////////////////////////
	// ALU on the top cells
	////////////////////////////////////////////////////////////////////////////

	// Default is a unary op in place
	always_comb begin
		wr_en  = 1'b1;
		wr_ptr = dp;
		nxt_dp = dp;
		result = tos;
		case (cmd.op)
			ds_none: wr_en = 1'b0;
			ds_push: begin
				wr_ptr = dp_up;
				nxt_dp = dp_up;
				result = cmd.arg;
			end
			ds_pop: begin
				wr_en  = 1'b0;
				nxt_dp = dp_dn;
			end
			// Two in, one out
			ds_add, ds_sub, ds_eq, ds_and, ds_or: begin
				wr_ptr = dp_dn;
				nxt_dp = dp_dn;
				case (cmd.op)
					ds_add: result = nos + tos;
					ds_sub: result = nos - tos;
					ds_eq: result = {`CELL_W{nos == tos}};
					ds_and: result = nos & tos;
					default: result = nos | tos;
				endcase
			end
			ds_dup: begin
				wr_ptr = dp_up;
				nxt_dp = dp_up;
			end
			ds_over: begin
				wr_ptr = dp_up;
				nxt_dp = dp_up;
				result = nos;
			end
			ds_inc: result = tos + 1'b1;
			// Flags are all ones or zero
			ds_zeq: result = {`CELL_W{tos == '0}};
			ds_zlt: result = {`CELL_W{tos[`CELL_W-1]}};
			ds_not: result = ~tos;
			ds_neg: result = -tos;
			ds_replace: result = cmd.arg;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			dp <= '0;
		end else begin
			dp <= nxt_dp;
		end
	end

	// Cell storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			cells[wr_ptr] <= result;
		end
	end

	// Sequencer must always drive a defined command
	assert property (@(posedge clk) disable iff (!reset) !$isunknown(cmd.op))
		else $error("undefined data stack command");

endmodule

/* verilog/return_stack.sv */
// Circular return stack of RSTACK_DEPTH addresses; deep nesting overwrites the oldest entry
`timescale 1ns/1ps
`include "forth_defines.svh"

module return_stack import forth_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  rs_cmd_t            cmd,
	output logic [`ADDR_W-1:0] rtop
);

	localparam int PTR_W = $clog2(`RSTACK_DEPTH);

	logic [`ADDR_W-1:0] ret [`RSTACK_DEPTH];
	logic [PTR_W-1:0]   rp;

	assign rtop = ret[rp];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rp <= '0;
		end else if (cmd.push) begin
			rp <= rp + 1'b1;
		end else if (cmd.pop) begin
			rp <= rp - 1'b1;
		end
	end

	// Return addresses, pre-increment on call
	always_ff @(posedge clk) begin
		if (cmd.push) begin
			ret[rp + 1'b1] <= cmd.ret_addr;
		end
	end

	// A call and an exit never share a cycle
	assert property (@(posedge clk) disable iff (!reset) !(cmd.push && cmd.pop))
		else $error("return stack push and pop together");

endmodule

/* verilog/forth_sequencer.sv */
// Inner interpreter; program memory must answer in the same cycle and unknown opcodes act as no-ops
`timescale 1ns/1ps
`include "forth_defines.svh"

module forth_sequencer import forth_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  cell_u              mem_cell,
	output logic [`ADDR_W-1:0] mem_addr,
	output ds_cmd_t            ds_cmd,
	input  logic [`CELL_W-1:0] tos,
	output rs_cmd_t            rs_cmd,
	input  logic [`ADDR_W-1:0] rtop,
	input  logic               xt_valid,
	input  logic [`ADDR_W-1:0] xt_head,
	output logic               xt_pop,
	output logic               tx_start,
	output logic [7:0]         tx_byte,
	input  logic               tx_busy,
	input  logic [1:0]         buttons,
	output logic [2:0]         leds
);

	typedef enum logic [1:0] {FETCH, OPERAND, EMIT_WAIT, XT_WAIT} state_e;

	state_e             state;
	state_e             nxt_state;
	op_e                op_q;
	logic [`ADDR_W-1:0] mp;
	logic [`ADDR_W-1:0] nxt_mp;
	logic [`ADDR_W-1:0] mp_inc;
	logic [`ADDR_W-1:0] call_target;
	logic [`ADDR_W-1:0] operand_addr;
	logic [1:0]         btn_meta;
	logic [1:0]         btn_sync;
	logic               led_wr;

	assign mem_addr     = mp;
	assign mp_inc       = mp + 1'b1;
	// Negative cell is a call to its negation
	assign call_target  = `ADDR_W'(-mem_cell.data);
	assign operand_addr = mem_cell.data[`ADDR_W-1:0];
	assign tx_byte      = tos[7:0];

	////////////////////////////////////////////////////////////////////////////
	// Decode and next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nxt_state = state;
		nxt_mp    = mp;
		ds_cmd    = '{op: ds_none, arg: '0};
		// Return address is always the next cell
		rs_cmd    = '{push: 1'b0, pop: 1'b0, ret_addr: mp_inc};
		xt_pop    = 1'b0;
		tx_start  = 1'b0;
		led_wr    = 1'b0;
		case (state)
			FETCH: begin
				nxt_mp = mp_inc;
				if (mem_cell.instr.call) begin
					rs_cmd.push = 1'b1;
					nxt_mp      = call_target;
				end else begin
					case (mem_cell.instr.op)
						op_lit, op_branch, op_zero_branch: nxt_state = OPERAND;
						op_plus: ds_cmd.op = ds_add;
						op_minus: ds_cmd.op = ds_sub;
						op_one_plus: ds_cmd.op = ds_inc;
						op_dup: ds_cmd.op = ds_dup;
						op_over: ds_cmd.op = ds_over;
						op_drop: ds_cmd.op = ds_pop;
						op_equal: ds_cmd.op = ds_eq;
						op_zero_equal: ds_cmd.op = ds_zeq;
						op_zero_less_than: ds_cmd.op = ds_zlt;
						op_and: ds_cmd.op = ds_and;
						op_or: ds_cmd.op = ds_or;
						op_not: ds_cmd.op = ds_not;
						op_negate: ds_cmd.op = ds_neg;
						// Byte leaves with the pop, then wait out the frame
						op_emit: begin
							ds_cmd.op = ds_pop;
							tx_start  = 1'b1;
							nxt_state = EMIT_WAIT;
						end
						op_io_led: begin
							ds_cmd.op = ds_pop;
							led_wr    = 1'b1;
						end
						op_io_button: begin
							ds_cmd.op  = ds_replace;
							ds_cmd.arg = `CELL_W'(btn_sync);
						end
						op_exit: begin
							rs_cmd.pop = 1'b1;
							nxt_mp     = rtop;
						end
						op_execute: begin
							if (xt_valid) begin
								xt_pop      = 1'b1;
								rs_cmd.push = 1'b1;
								nxt_mp      = xt_head;
							end else begin
								// Hold on the execute cell
								nxt_mp    = mp;
								nxt_state = XT_WAIT;
							end
						end
						default: ;
					endcase
				end
			end
			// mp now points at the inline operand
			OPERAND: begin
				nxt_state = FETCH;
				nxt_mp    = mp_inc;
				case (op_q)
					op_lit: begin
						ds_cmd.op  = ds_push;
						ds_cmd.arg = mem_cell.data;
					end
					op_branch: nxt_mp = operand_addr;
					op_zero_branch: begin
						ds_cmd.op = ds_pop;
						if (tos == '0) begin
							nxt_mp = operand_addr;
						end
					end
					default: ;
				endcase
			end
			EMIT_WAIT: begin
				if (!tx_busy) begin
					nxt_state = FETCH;
				end
			end
			XT_WAIT: begin
				if (xt_valid) begin
					xt_pop      = 1'b1;
					rs_cmd.push = 1'b1;
					nxt_mp      = xt_head;
					nxt_state   = FETCH;
				end
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= FETCH;
			mp       <= `ADDR_W'(`IDLE_LOOP);
			op_q     <= op_execute;
			// LEDs are active low, start dark
			leds     <= 3'b111;
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			state    <= nxt_state;
			mp       <= nxt_mp;
			btn_meta <= buttons;
			btn_sync <= btn_meta;
			// Remember which op owns the operand
			if (state == FETCH) begin
				op_q <= mem_cell.instr.op;
			end
			if (led_wr) begin
				leds <= ~tos[2:0];
			end
		end
	end

endmodule

/* verilog/uart_tx.sv */
// 8N1 transmitter with LSB first; tx_start must only come while tx_busy is low
`timescale 1ns/1ps
`include "forth_defines.svh"

module uart_tx #(
	parameter int baud_div = `BAUD_DIV
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       tx
);

	localparam int TIMER_W = $clog2(baud_div);

	logic [TIMER_W-1:0] bit_timer;
	logic [3:0]         bit_cnt;
	logic [8:0]         shifter;
	logic               bit_end;

	// Last clock of the current bit
	assign bit_end = bit_timer == TIMER_W'(baud_div - 1);

	// bit_cnt 0 is start, 1 to 8 data, 9 stop
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tx_busy   <= 1'b0;
			tx        <= 1'b1;
			bit_timer <= '0;
			bit_cnt   <= '0;
		end else if (!tx_busy) begin
			bit_timer <= '0;
			bit_cnt   <= '0;
			if (tx_start) begin
				tx_busy <= 1'b1;
				tx      <= 1'b0;
			end
		end else if (bit_end) begin
			bit_timer <= '0;
			if (bit_cnt == 4'd9) begin
				// Stop bit done, line stays high
				tx_busy <= 1'b0;
			end else begin
				tx      <= shifter[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			bit_timer <= bit_timer + 1'b1;
		end
	end

	// Data plus stop bit, ones shift in behind
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start) begin
			shifter <= {1'b1, tx_byte};
		end else if (tx_busy && bit_end) begin
			shifter <= {1'b1, shifter[8:1]};
		end
	end

	// Sequencer must hold in emit until the frame ends
	assert property (@(posedge clk) disable iff (!reset) tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

/* verilog/forth_core.sv */
// Forth core top; the host owns XTQ_DEPTH token credits after reset and code writes land in RAM only
`timescale 1ns/1ps
`include "forth_defines.svh"

module forth_core import forth_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  code_wr_t           code_wr,
	input  logic               xt_push,
	input  logic [`ADDR_W-1:0] xt_addr,
	output logic               xt_credit,
	input  logic [1:0]         buttons,
	output logic               tx,
	output logic               led_g,
	output logic               led_b,
	output logic               led_r
);

	logic [`ADDR_W-1:0] mem_addr;
	cell_u              mem_cell;
	ds_cmd_t            ds_cmd;
	logic [`CELL_W-1:0] tos;
	rs_cmd_t            rs_cmd;
	logic [`ADDR_W-1:0] rtop;
	logic               xt_valid;
	logic [`ADDR_W-1:0] xt_head;
	logic               xt_pop;
	logic               tx_start;
	logic [7:0]         tx_byte;
	logic               tx_busy;

	program_memory u_mem (
		.clk      (clk),
		.reset    (reset),
		.mem_addr (mem_addr),
		.code_wr  (code_wr),
		.mem_cell (mem_cell)
	);

	xt_queue u_xtq (
		.clk       (clk),
		.reset     (reset),
		.xt_push   (xt_push),
		.xt_addr   (xt_addr),
		.xt_pop    (xt_pop),
		.xt_valid  (xt_valid),
		.xt_head   (xt_head),
		.xt_credit (xt_credit)
	);

	// Second cell is only needed inside the ALU
	data_stack u_ds (
		.clk   (clk),
		.reset (reset),
		.cmd   (ds_cmd),
		.tos   (tos),
		.nos   ()
	);

	return_stack u_rs (
		.clk   (clk),
		.reset (reset),
		.cmd   (rs_cmd),
		.rtop  (rtop)
	);

	// LED bits 0 to 2 are green, blue, red
	forth_sequencer u_seq (
		.clk      (clk),
		.reset    (reset),
		.mem_cell (mem_cell),
		.mem_addr (mem_addr),
		.ds_cmd   (ds_cmd),
		.tos      (tos),
		.rs_cmd   (rs_cmd),
		.rtop     (rtop),
		.xt_valid (xt_valid),
		.xt_head  (xt_head),
		.xt_pop   (xt_pop),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.buttons  (buttons),
		.leds     ({led_r, led_b, led_g})
	);

	uart_tx #(
		.baud_div (`BAUD_DIV)
	) u_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

endmodule

/* testbench/forth_core_tb.sv */
// RAM code sits from address 300 upward and each serial frame lasts 10 * BAUD_DIV cycles
`timescale 1ns/1ps
`include "forth_defines.svh"

module forth_core_tb import forth_pkg::*; ();

	localparam int FRAME_CYCLES   = 10 * `BAUD_DIV;
	// Serial frames sent over the whole run
	localparam int N_FRAMES       = 7;
	localparam int TIMEOUT_CYCLES = 4 * N_FRAMES * FRAME_CYCLES + 25000;
	localparam int CREDIT_WAIT    = 2 * FRAME_CYCLES;
	localparam int ERROR_WORD     = 11;
	localparam int N_COUNT        = 3;

	localparam logic [`ADDR_W-1:0] ARITH_ADDR = 300;
	localparam logic [`ADDR_W-1:0] EMIT_ADDR  = 320;
	localparam logic [`ADDR_W-1:0] CALL_ADDR  = 330;
	localparam logic [`ADDR_W-1:0] LOOP_ADDR  = 340;
	localparam logic [`ADDR_W-1:0] FIRST_ADDR = 360;
	localparam logic [`ADDR_W-1:0] SECOND_ADDR = 370;
	localparam logic [`ADDR_W-1:0] BTN_ADDR   = 380;

	logic               clk;
	logic               reset;
	code_wr_t           code_wr;
	logic               xt_push;
	logic [`ADDR_W-1:0] xt_addr;
	logic               xt_credit;
	logic [1:0]         buttons;
	logic               tx;
	logic               led_g;
	logic               led_b;
	logic               led_r;

	int                 errors;
	int                 tests;
	int                 failed_tests;
	int                 credits;
	int                 credit_pulses;
	int                 cycles;
	logic [7:0]         rx_q [$];
	logic [31:0]        prog_q [$];
	logic [7:0]         rx_byte;

	forth_core dut_i (
		.clk       (clk),
		.reset     (reset),
		.code_wr   (code_wr),
		.xt_push   (xt_push),
		.xt_addr   (xt_addr),
		.xt_credit (xt_credit),
		.buttons   (buttons),
		.tx        (tx),
		.led_g     (led_g),
		.led_b     (led_b),
		.led_r     (led_r)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////////////////////

	// Host gets one credit back per pulse
	initial begin
		forever begin
			@(negedge clk);
			if (reset && xt_credit) begin
				credit_pulses++;
				credits++;
			end
		end
	end

	// Serial decoder sampling each bit in its middle
	always begin
		@(negedge clk);
		if (reset && tx === 1'b0) begin
			repeat (`BAUD_DIV / 2) @(negedge clk);
			// Start bit still low in its middle
			if (tx === 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (`BAUD_DIV) @(negedge clk);
					rx_byte[i] = tx;
				end
				repeat (`BAUD_DIV) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("framing error: stop bit not high at %0t", $time);
					errors++;
				end else begin
					rx_q.push_back(rx_byte);
				end
			end
		end
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR t=%0t %s: got %h expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// Opcode cell with call flag and spare field clear
	function automatic logic [31:0] op_cell(input op_e op);
		return {16'h0000, op};
	endfunction

	task automatic add_cell(input logic [31:0] data);
		prog_q.push_back(data);
	endtask

	// One write per clock and valid drops after the last
	task automatic load_program(input logic [`ADDR_W-1:0] base);
		for (int i = 0; i < prog_q.size(); i++) begin
			@(posedge clk);
			code_wr <= '{valid: 1'b1, addr: base + `ADDR_W'(i), data: prog_q[i]};
		end
		@(posedge clk);
		code_wr <= '0;
		prog_q.delete();
	endtask

	task automatic push_token(input logic [`ADDR_W-1:0] addr);
		int n;
		n = 0;
		if (credits == 0) begin
			@(posedge clk);
			xt_push <= 1'b0;
			while (credits == 0 && n < CREDIT_WAIT) begin
				@(negedge clk);
				n++;
			end
		end
		if (credits == 0) begin
			$display("no token credit came back within %0d cycles", CREDIT_WAIT);
			errors++;
		end else begin
			@(posedge clk);
			xt_push <= 1'b1;
			xt_addr <= addr;
			credits--;
		end
	endtask

	task automatic release_push();
		@(posedge clk);
		xt_push <= 1'b0;
	endtask

	task automatic wait_pulses(input int target);
		int n;
		n = 0;
		while (credit_pulses < target && n < CREDIT_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (credit_pulses < target) begin
			$display("token was not taken: no credit pulse within %0d cycles", CREDIT_WAIT);
			errors++;
		end
	endtask

	task automatic wait_bytes(input int count);
		int n;
		int limit;
		n = 0;
		limit = count * (FRAME_CYCLES + 400) + 400;
		while (rx_q.size() < count && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (rx_q.size() < count) begin
			$display("expected %0d bytes on the serial line, got %0d", count, rx_q.size());
			errors++;
		end
	endtask

	// Push a token and wait until it is taken and the word has finished
	task automatic run_token(input logic [`ADDR_W-1:0] addr);
		int target;
		target = credit_pulses + 1;
		push_token(addr);
		release_push();
		wait_pulses(target);
		repeat (20) @(negedge clk);
	endtask

	task automatic check_byte(input logic [7:0] expected);
		if (rx_q.size() > 0) begin
			compare_value("rx_byte", rx_q.pop_front(), expected);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	// Forth semantics with b on top and a below it
	function automatic logic [31:0] model_op(input op_e op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			op_plus: return a + b;
			op_minus: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_not: return ~b;
			default: return -b;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_values();
		int err0;
		err0 = errors;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			compare_value("tx", tx, 1'b1);
			compare_value("led_g", led_g, 1'b1);
			compare_value("led_b", led_b, 1'b1);
			compare_value("led_r", led_r, 1'b1);
			compare_value("xt_credit", xt_credit, 1'b0);
		end
		report_test("reset", err0);
	endtask

	task automatic alu_ops();
		op_e         ops [6];
		op_e         op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [2:0]  exp_led;
		int          err0;
		err0 = errors;
		ops = '{op_plus, op_minus, op_and, op_or, op_not, op_negate};
		// Two rounds over the ALU ops
		for (int k = 0; k < 12; k++) begin
			op = ops[k % 6];
			a = $urandom;
			b = $urandom;
			add_cell(op_cell(op_lit));
			add_cell(a);
			add_cell(op_cell(op_lit));
			add_cell(b);
			add_cell(op_cell(op));
			add_cell(op_cell(op_io_led));
			add_cell(op_cell(op_exit));
			load_program(ARITH_ADDR);
			run_token(ARITH_ADDR);
			r = model_op(op, a, b);
			exp_led = ~r[2:0];
			compare_value("led_g", led_g, exp_led[0]);
			compare_value("led_b", led_b, exp_led[1]);
			compare_value("led_r", led_r, exp_led[2]);
		end
		report_test("arith", err0);
	endtask

	task automatic emit_byte();
		logic [31:0] x;
		int          err0;
		err0 = errors;
		x = $urandom;
		rx_q.delete();
		add_cell(op_cell(op_lit));
		add_cell(x);
		add_cell(op_cell(op_emit));
		add_cell(op_cell(op_exit));
		load_program(EMIT_ADDR);
		run_token(EMIT_ADDR);
		wait_bytes(1);
		check_byte(x[7:0]);
		repeat (`BAUD_DIV) @(negedge clk);
		report_test("emit", err0);
	endtask

	// Negative cell calls the ROM error word
	task automatic call_error_word();
		int err0;
		err0 = errors;
		rx_q.delete();
		add_cell(-32'(ERROR_WORD));
		add_cell(op_cell(op_exit));
		load_program(CALL_ADDR);
		run_token(CALL_ADDR);
		wait_bytes(1);
		check_byte(8'h3f);
		repeat (`BAUD_DIV) @(negedge clk);
		report_test("call_error", err0);
	endtask

	// Emits N_COUNT down to 1
	task automatic countdown_loop();
		int err0;
		err0 = errors;
		rx_q.delete();
		add_cell(op_cell(op_lit));
		add_cell(N_COUNT);
		// Loop body at LOOP_ADDR + 2
		add_cell(op_cell(op_dup));
		add_cell(op_cell(op_emit));
		add_cell(op_cell(op_lit));
		add_cell(32'd1);
		add_cell(op_cell(op_minus));
		add_cell(op_cell(op_dup));
		add_cell(op_cell(op_zero_equal));
		add_cell(op_cell(op_zero_branch));
		add_cell(32'(LOOP_ADDR + 2));
		add_cell(op_cell(op_drop));
		add_cell(op_cell(op_exit));
		load_program(LOOP_ADDR);
		run_token(LOOP_ADDR);
		wait_bytes(N_COUNT);
		for (int i = N_COUNT; i > 0; i--) begin
			check_byte(8'(i));
		end
		compare_value("extra_bytes", rx_q.size(), 0);
		repeat (`BAUD_DIV) @(negedge clk);
		report_test("countdown", err0);
	endtask

	task automatic credit_flow();
		logic [7:0] b1;
		logic [7:0] b2;
		int         err0;
		int         pulses0;
		err0 = errors;
		b1 = 8'($urandom);
		b2 = b1 ^ 8'h5a;
		rx_q.delete();
		add_cell(op_cell(op_lit));
		add_cell(32'(b1));
		add_cell(op_cell(op_emit));
		add_cell(op_cell(op_exit));
		load_program(FIRST_ADDR);
		add_cell(op_cell(op_lit));
		add_cell(32'(b2));
		add_cell(op_cell(op_emit));
		add_cell(op_cell(op_exit));
		load_program(SECOND_ADDR);
		pulses0 = credit_pulses;
		// Both credits spent on consecutive clocks
		push_token(FIRST_ADDR);
		push_token(SECOND_ADDR);
		release_push();
		wait_bytes(2);
		wait_pulses(pulses0 + 2);
		check_byte(b1);
		check_byte(b2);
		repeat (`BAUD_DIV) @(negedge clk);
		compare_value("credit_pulses", credit_pulses - pulses0, 2);
		compare_value("credits", credits, `XTQ_DEPTH);
		report_test("credit_flow", err0);
	endtask

	task automatic button_leds();
		logic [1:0] b;
		int         err0;
		err0 = errors;
		add_cell(op_cell(op_io_button));
		add_cell(op_cell(op_io_led));
		add_cell(op_cell(op_exit));
		load_program(BTN_ADDR);
		for (int k = 0; k < 4; k++) begin
			b = 2'($urandom);
			@(posedge clk);
			buttons <= b;
			// Let the synchronizer settle
			repeat (4) @(posedge clk);
			run_token(BTN_ADDR);
			compare_value("led_g", led_g, !b[0]);
			compare_value("led_b", led_b, !b[1]);
			compare_value("led_r", led_r, 1'b1);
		end
		report_test("buttons", err0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hb1647ea7));
		errors        = 0;
		tests         = 0;
		failed_tests  = 0;
		credit_pulses = 0;
		credits       = `XTQ_DEPTH;
		reset         = 1'b0;
		code_wr       = '0;
		xt_push       = 1'b0;
		xt_addr       = '0;
		buttons       = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
		reset_values();
		alu_ops();
		emit_byte();
		call_error_word();
		countdown_loop();
		credit_flow();
		button_leds();
		$display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0 && failed_tests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* forth_core.f */
+incdir+include
verilog/forth_pkg.sv
verilog/program_memory.sv
verilog/xt_queue.sv
verilog/data_stack.sv
verilog/return_stack.sv
verilog/forth_sequencer.sv
verilog/uart_tx.sv
verilog/forth_core.sv
testbench/forth_core_tb.sv
